/* verilog/noun_pkg.sv */
package noun_pkg;

   // Memory geometry
   localparam int addr_w = 10;

   // Cell field widths
   localparam int noun_w = 27;
   localparam int tag_w  = 8;
   localparam int word_w = tag_w + 2 * noun_w;

   // Field positions inside a word, tag on top, tail at the bottom
   localparam int tel_lsb = 0;
   localparam int hed_lsb = noun_w;
   localparam int tag_lsb = 2 * noun_w;

   // One memory word holds one cell
   typedef logic [word_w-1:0] word_t;

   typedef logic [addr_w-1:0] addr_t;

   // Head or tail field; a pointer lives in the low addr_w bits
   typedef logic [noun_w-1:0] noun_t;

   typedef logic [tag_w-1:0] tag_t;

   // Tag bit positions
   localparam int tag_exec_bit     = 7;
   localparam int tag_hed_seen_bit = 3;
   localparam int tag_tel_seen_bit = 2;
   localparam int tag_hed_cell_bit = 1;
   localparam int tag_tel_cell_bit = 0;

   // End sentinel, the back pointer of the root
   localparam addr_t nil_addr = '1;

endpackage

/* verilog/walk_pkg.sv */
package walk_pkg;

   // Memory function codes on the strobe interface
   typedef enum logic [1:0] {
      mem_get = 2'd0,
      mem_set = 2'd1
   } mem_func_t;

   // Walker FSM states
   typedef enum logic [3:0] {
      st_idle       = 4'd0,
      st_read       = 4'd1,
      st_read_wait  = 4'd2,
      st_decide     = 4'd3,
      st_tel_step   = 4'd4,
      st_write      = 4'd5,
      st_write_wait = 4'd6,
      st_move       = 4'd7,
      st_done       = 4'd8
   } walk_state_t;

   // Operations the controller asks of the node datapath
   typedef enum logic [3:0] {
      op_none        = 4'd0,
      // Capture a word returned by memory
      op_load        = 4'd1,
      // Descend into a child, leaving the back pointer behind
      op_push_hed    = 4'd2,
      op_swap_to_tel = 4'd3,
      op_push_tel    = 4'd4,
      // Climb out of a child, restoring its pointer
      op_pop_hed     = 4'd5,
      op_pop_tel     = 4'd6,
      // Change the current address
      op_goto_back   = 4'd7,
      op_goto_next   = 4'd8
   } node_op_t;

endpackage

/* verilog/node_datapath.sv */
module node_datapath (
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  noun_pkg::addr_t    start_addr,
   input  walk_pkg::node_op_t node_op,
   input  noun_pkg::word_t    read_data,
   output noun_pkg::tag_t     cur_tag,
   output noun_pkg::addr_t    cur_addr,
   output noun_pkg::word_t    cur_word,
   output logic               at_nil
);

   // Captured cell
   noun_pkg::tag_t  tag;
   noun_pkg::noun_t hed;
   noun_pkg::noun_t tel;

   // Next address and back pointer
   noun_pkg::noun_t p;
   noun_pkg::noun_t b;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         p        <= '0;
         b        <= noun_pkg::noun_t'(noun_pkg::nil_addr);
         cur_addr <= noun_pkg::nil_addr;
      end else if (!run) begin
         // Idle, prime the walk at the root
         p        <= noun_pkg::noun_t'(start_addr);
         b        <= noun_pkg::noun_t'(noun_pkg::nil_addr);
         cur_addr <= start_addr;
      end else begin
         case (node_op)
            walk_pkg::op_push_hed: begin
               p <= hed;
               b <= p;
            end
            walk_pkg::op_push_tel: begin
               p <= tel;
               b <= p;
            end
            walk_pkg::op_swap_to_tel, walk_pkg::op_pop_hed: begin
               b <= hed;
               p <= b;
            end
            walk_pkg::op_pop_tel: begin
               b <= tel;
               p <= b;
            end
            walk_pkg::op_goto_next: cur_addr <= p[noun_pkg::addr_w-1:0];
            walk_pkg::op_goto_back: cur_addr <= b[noun_pkg::addr_w-1:0];
            default: ;
         endcase
      end
   end

   // Cell fields follow the same ops, old p and b on the right
   always_ff @(posedge clk) begin
      case (node_op)
         walk_pkg::op_load: begin
            tag <= read_data[noun_pkg::tag_lsb +: noun_pkg::tag_w];
            hed <= read_data[noun_pkg::hed_lsb +: noun_pkg::noun_w];
            tel <= read_data[noun_pkg::tel_lsb +: noun_pkg::noun_w];
         end
         walk_pkg::op_push_hed: begin
            tag[noun_pkg::tag_hed_seen_bit] <= 1'b1;
            hed <= b;
         end
         walk_pkg::op_push_tel: begin
            tag[noun_pkg::tag_tel_seen_bit] <= 1'b1;
            tel <= b;
         end
         walk_pkg::op_swap_to_tel: hed <= p;
         walk_pkg::op_pop_hed: begin
            tag[noun_pkg::tag_hed_seen_bit] <= 1'b0;
            tag[noun_pkg::tag_tel_seen_bit] <= 1'b0;
            hed <= p;
         end
         walk_pkg::op_pop_tel: begin
            tag[noun_pkg::tag_hed_seen_bit] <= 1'b0;
            tag[noun_pkg::tag_tel_seen_bit] <= 1'b0;
            tel <= p;
         end
         default: ;
      endcase
   end

   assign cur_tag  = tag;
   assign cur_word = {tag, hed, tel};
   assign at_nil   = (cur_addr == noun_pkg::nil_addr);

endmodule

/* verilog/mem_port.sv */
module mem_port (
   input  logic                clk,
   input  logic                rst,
   input  logic                req,
   input  walk_pkg::mem_func_t req_func,
   input  noun_pkg::addr_t     cur_addr,
   input  noun_pkg::word_t     cur_word,
   input  logic                mem_ready,
   output logic                mem_execute,
   output noun_pkg::addr_t     address,
   output walk_pkg::mem_func_t mem_func,
   output noun_pkg::word_t     write_data,
   output logic                done
);

   // One request in flight at most
   logic pending;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         mem_execute <= 1'b0;
         pending     <= 1'b0;
      end else begin
         // Strobe lasts a single cycle
         mem_execute <= req;
         if (req) begin
            pending <= 1'b1;
         end else if (mem_ready) begin
            pending <= 1'b0;
         end
      end
   end

   // Request fields latched with the strobe
   always_ff @(posedge clk) begin
      if (req) begin
         address    <= cur_addr;
         mem_func   <= req_func;
         write_data <= cur_word;
      end
   end

   // Stray ready pulses with nothing outstanding are dropped
   assign done = pending & mem_ready;

endmodule

/* verilog/walk_control.sv */
module walk_control (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  logic                done,
   input  noun_pkg::tag_t      cur_tag,
   input  logic                at_nil,
   output logic                req,
   output walk_pkg::mem_func_t req_func,
   output walk_pkg::node_op_t  node_op,
   output logic                finished
);

   walk_pkg::walk_state_t state;
   walk_pkg::walk_state_t state_nxt;

   // Direction of the next move, set by the decide step
   logic dir_back;
   logic dir_back_nxt;

   logic hed_cell;
   logic tel_cell;
   logic hed_seen;
   logic tel_seen;

   assign hed_cell = cur_tag[noun_pkg::tag_hed_cell_bit];
   assign tel_cell = cur_tag[noun_pkg::tag_tel_cell_bit];
   assign hed_seen = cur_tag[noun_pkg::tag_hed_seen_bit];
   assign tel_seen = cur_tag[noun_pkg::tag_tel_seen_bit];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state    <= walk_pkg::st_idle;
         dir_back <= 1'b0;
      end else begin
         state    <= state_nxt;
         dir_back <= dir_back_nxt;
      end
   end

   always_comb begin
      state_nxt    = state;
      dir_back_nxt = dir_back;
      req          = 1'b0;
      req_func     = walk_pkg::mem_get;
      node_op      = walk_pkg::op_none;

      // Wait states finish their access before dropping back to idle
      if (!run && state != walk_pkg::st_read_wait && state != walk_pkg::st_write_wait) begin
         state_nxt = walk_pkg::st_idle;
      end else begin
         case (state)
            walk_pkg::st_idle: begin
               state_nxt = walk_pkg::st_read;
            end

            walk_pkg::st_read: begin
               // Back past the root
               if (at_nil) begin
                  state_nxt = walk_pkg::st_done;
               end else begin
                  req       = 1'b1;
                  req_func  = walk_pkg::mem_get;
                  state_nxt = walk_pkg::st_read_wait;
               end
            end

            walk_pkg::st_read_wait: begin
               if (done) begin
                  node_op   = walk_pkg::op_load;
                  state_nxt = run ? walk_pkg::st_decide : walk_pkg::st_idle;
               end
            end

            walk_pkg::st_decide: begin
               state_nxt = walk_pkg::st_write;
               case ({hed_cell, tel_cell})
                  2'b11: begin
                     if (!hed_seen) begin
                        node_op      = walk_pkg::op_push_hed;
                        dir_back_nxt = 1'b0;
                     end else if (!tel_seen) begin
                        // Restore the head now, push the tail next cycle
                        node_op   = walk_pkg::op_swap_to_tel;
                        state_nxt = walk_pkg::st_tel_step;
                     end else begin
                        node_op      = walk_pkg::op_pop_tel;
                        dir_back_nxt = 1'b1;
                     end
                  end
                  2'b10: begin
                     node_op      = hed_seen ? walk_pkg::op_pop_hed : walk_pkg::op_push_hed;
                     dir_back_nxt = hed_seen;
                  end
                  2'b01: begin
                     node_op      = tel_seen ? walk_pkg::op_pop_tel : walk_pkg::op_push_tel;
                     dir_back_nxt = tel_seen;
                  end
                  default: begin
                     // Leaf cell, nothing to rewrite
                     dir_back_nxt = 1'b1;
                     state_nxt    = walk_pkg::st_move;
                  end
               endcase
            end

            walk_pkg::st_tel_step: begin
               node_op      = walk_pkg::op_push_tel;
               dir_back_nxt = 1'b0;
               state_nxt    = walk_pkg::st_write;
            end

            walk_pkg::st_write: begin
               req       = 1'b1;
               req_func  = walk_pkg::mem_set;
               state_nxt = walk_pkg::st_write_wait;
            end

            walk_pkg::st_write_wait: begin
               if (done) begin
                  state_nxt = run ? walk_pkg::st_move : walk_pkg::st_idle;
               end
            end

            walk_pkg::st_move: begin
               node_op   = dir_back ? walk_pkg::op_goto_back : walk_pkg::op_goto_next;
               state_nxt = walk_pkg::st_read;
            end

            walk_pkg::st_done: begin
               state_nxt = walk_pkg::st_done;
            end

            default: begin
               state_nxt = walk_pkg::st_idle;
            end
         endcase
      end
   end

   // Held until run falls
   assign finished = (state == walk_pkg::st_done);

endmodule

/* verilog/tree_walker.sv */
module tree_walker (
   input  logic                clk,
   input  logic                rst,
   input  logic                run,
   input  noun_pkg::addr_t     start_addr,
   input  logic                mem_ready,
   input  noun_pkg::word_t     read_data,
   output logic                mem_execute,
   output noun_pkg::addr_t     address,
   output walk_pkg::mem_func_t mem_func,
   output noun_pkg::word_t     write_data,
   output logic                finished
);

   // Controller to memory port
   logic                req;
   walk_pkg::mem_func_t req_func;
   logic                done;

   // Controller to datapath and back
   walk_pkg::node_op_t  node_op;
   noun_pkg::tag_t      cur_tag;
   logic                at_nil;

   // Datapath to memory port
   noun_pkg::addr_t     cur_addr;
   noun_pkg::word_t     cur_word;

   walk_control u_control (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .done     (done),
      .cur_tag  (cur_tag),
      .at_nil   (at_nil),
      .req      (req),
      .req_func (req_func),
      .node_op  (node_op),
      .finished (finished)
   );

   // Read data is only captured on op_load, which the controller issues with done
   node_datapath u_datapath (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .start_addr (start_addr),
      .node_op    (node_op),
      .read_data  (read_data),
      .cur_tag    (cur_tag),
      .cur_addr   (cur_addr),
      .cur_word   (cur_word),
      .at_nil     (at_nil)
   );

   mem_port u_mem_port (
      .clk         (clk),
      .rst         (rst),
      .req         (req),
      .req_func    (req_func),
      .cur_addr    (cur_addr),
      .cur_word    (cur_word),
      .mem_ready   (mem_ready),
      .mem_execute (mem_execute),
      .address     (address),
      .mem_func    (mem_func),
      .write_data  (write_data),
      .done        (done)
   );

endmodule

/* verification/tree_walker_assert.sv */
module tree_walker_assert #(
   parameter bit has_fsm = 1'b1
) (
   input logic                  clk,
   input logic                  rst,
   input logic                  run,
   input logic                  finished,
   input walk_pkg::walk_state_t state,
   input logic                  strobe,
   input logic                  ready
);

   int fail_count;

   // Strobe seen, ready not yet
   logic outstanding;

   initial fail_count = 0;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         outstanding <= 1'b0;
      end else if (strobe) begin
         outstanding <= 1'b1;
      end else if (ready) begin
         outstanding <= 1'b0;
      end
   end

   // Request strobe is a single-cycle pulse
   strobe_one_cycle: assert property (@(posedge clk) disable iff (!rst) strobe |=> !strobe)
      else begin
         fail_count++;
         $error("request strobe held for more than one cycle");
      end

   // One request in flight
   strobe_waits_ready: assert property (@(posedge clk) disable iff (!rst)
      strobe |-> (!outstanding || ready))
      else begin
         fail_count++;
         $error("new request strobe issued before ready");
      end

   // Walker-level checks, only where the FSM is attached
   if (has_fsm) begin : g_fsm
      finished_holds: assert property (@(posedge clk) disable iff (!rst)
         (finished && run) |=> (finished || !run))
         else begin
            fail_count++;
            $error("finished dropped while run was high");
         end

      idle_after_reset: assert property (@(posedge clk) $rose(rst) |-> state == walk_pkg::st_idle)
         else begin
            fail_count++;
            $error("walker not idle after reset");
         end
   end

endmodule

bind walk_control tree_walker_assert u_ctrl_assert (
   .clk      (clk),
   .rst      (rst),
   .run      (run),
   .finished (finished),
   .state    (state),
   .strobe   (req),
   .ready    (done)
);

// The port has no FSM, only the strobe checks apply here
bind mem_port tree_walker_assert #(.has_fsm(1'b0)) u_port_assert (
   .clk      (clk),
   .rst      (rst),
   .run      (1'b1),
   .finished (1'b0),
   .state    (walk_pkg::st_idle),
   .strobe   (mem_execute),
   .ready    (mem_ready)
);

/* verification/tree_walker_tests.svh */
`ifndef TREE_WALKER_TESTS_SVH
`define TREE_WALKER_TESTS_SVH

task automatic clear_image();
   for (int a = 0; a < 1024; a++) begin
      image[a] = fill_word(noun_pkg::addr_t'(a));
   end
endtask

// Chain of n cells, each linking to the next by head (left) or tail
task automatic build_chain(input logic left, input int n, output noun_pkg::addr_t root);
   noun_pkg::addr_t a;
   noun_pkg::tag_t  t;
   noun_pkg::noun_t h;
   noun_pkg::noun_t l;
   clear_image();
   for (int i = 0; i < n; i++) begin
      a = noun_pkg::addr_t'(10'h080 + 13 * i);
      t = noun_pkg::tag_t'(rand_below(16) << 4);
      h = noun_pkg::noun_t'(next_rand());
      l = noun_pkg::noun_t'(next_rand());
      if (i < n - 1 && left) begin
         t[noun_pkg::tag_hed_cell_bit] = 1'b1;
         h = noun_pkg::noun_t'(a + 10'd13);
      end else if (i < n - 1) begin
         t[noun_pkg::tag_tel_cell_bit] = 1'b1;
         l = noun_pkg::noun_t'(a + 10'd13);
      end
      image[a] = {t, h, l};
   end
   root = 10'h080;
endtask

task automatic build_random_tree(input int n, output noun_pkg::addr_t root);
   noun_pkg::addr_t at [40];
   int              hk [40];
   int              tk [40];
   bit              used [1024];
   int              j;
   noun_pkg::tag_t  t;
   noun_pkg::noun_t h;
   noun_pkg::noun_t l;
   clear_image();
   for (int i = 0; i < n; i++) begin
      hk[i] = -1;
      tk[i] = -1;
      // Distinct addresses, never the sentinel
      do begin
         at[i] = noun_pkg::addr_t'(rand_below(1024));
      end while (used[at[i]] || at[i] == noun_pkg::nil_addr);
      used[at[i]] = 1'b1;
      if (i > 0) begin
         // Hang the new cell on a free half of an earlier one
         do begin
            j = rand_below(i);
         end while (hk[j] >= 0 && tk[j] >= 0);
         if (hk[j] < 0 && (tk[j] >= 0 || rand_below(2) == 0)) begin
            hk[j] = i;
         end else begin
            tk[j] = i;
         end
      end
   end
   for (int i = 0; i < n; i++) begin
      t = noun_pkg::tag_t'(rand_below(16) << 4);
      h = noun_pkg::noun_t'(next_rand());
      l = noun_pkg::noun_t'(next_rand());
      if (hk[i] >= 0) begin
         t[noun_pkg::tag_hed_cell_bit] = 1'b1;
         h = noun_pkg::noun_t'(at[hk[i]]);
      end
      if (tk[i] >= 0) begin
         t[noun_pkg::tag_tel_cell_bit] = 1'b1;
         l = noun_pkg::noun_t'(at[tk[i]]);
      end
      image[at[i]] = {t, h, l};
   end
   root = at[0];
endtask

task automatic leaf_root_walk();
   noun_pkg::tag_t t;
   clear_image();
   t = '0;
   t[noun_pkg::tag_exec_bit] = 1'b1;
   image[10'h2c7] = {t, noun_pkg::noun_t'(next_rand()), noun_pkg::noun_t'(next_rand())};
   run_walk(10'h2c7);
   check_flag(obs_addr.size() == 1, 1'b1, "leaf root makes a single access");
   check_func(obs_func[0], walk_pkg::mem_get, "leaf root access");
endtask

task automatic chain_walks();
   noun_pkg::addr_t root;
   build_chain(1'b1, 7, root);
   run_walk(root);
   build_chain(1'b0, 7, root);
   run_walk(root);
endtask

task automatic random_tree_walks();
   noun_pkg::addr_t root;
   for (int k = 0; k < 8; k++) begin
      build_random_tree((k == 0) ? 40 : 1 + rand_below(40), root);
      run_walk(root);
   end
endtask

// Reset lands mid walk, then the same tree is walked again from a fresh copy
task automatic reset_mid_walk();
   noun_pkg::addr_t root;
   build_random_tree(30, root);
   start_walk(root);
   while (obs_addr.size() < 8) begin
      @(posedge clk);
   end
   @(negedge clk);
   rst = 1'b0;
   run = 1'b0;
   repeat (4) begin
      @(negedge clk);
      check_flag(mem_execute, 1'b0, "mem_execute during reset");
      check_flag(finished, 1'b0, "finished during reset");
   end
   rst = 1'b1;
   run_walk(root);
endtask

`endif

/* verification/tree_walker_tb.sv */
module tree_walker_tb;

   logic                clk;
   logic                rst;
   logic                run;
   noun_pkg::addr_t     start_addr;
   logic                mem_ready;
   noun_pkg::word_t     read_data;
   logic                mem_execute;
   noun_pkg::addr_t     address;
   walk_pkg::mem_func_t mem_func;
   noun_pkg::word_t     write_data;
   logic                finished;

   // Live memory and the pristine copy of the current tree
   noun_pkg::word_t mem [1024];
   noun_pkg::word_t image [1024];

   walk_pkg::mem_func_t exp_func [$];
   noun_pkg::addr_t     exp_addr [$];
   noun_pkg::word_t     exp_data [$];
   walk_pkg::mem_func_t obs_func [$];
   noun_pkg::addr_t     obs_addr [$];
   noun_pkg::word_t     obs_data [$];

   logic [31:0] lcg_state = 32'hef9a8fb9;
   int errors = 0;
   int checks = 0;
   int assert_fails;
   int cycle_cnt = 0;
   int cycle_limit = 100;

   // Memory model state
   logic                busy = 1'b0;
   int                  wait_cnt;
   noun_pkg::addr_t     req_addr;
   walk_pkg::mem_func_t req_fn;
   noun_pkg::word_t     req_data;

   tree_walker dut0 (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .start_addr  (start_addr),
      .mem_ready   (mem_ready),
      .read_data   (read_data),
      .mem_execute (mem_execute),
      .address     (address),
      .mem_func    (mem_func),
      .write_data  (write_data),
      .finished    (finished)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Limit grows by 200 cycles per expected access as walks are set up
   initial begin
      while (cycle_cnt <= cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("TIMEOUT: the walk hung, %0d cycles passed the limit of %0d",
               cycle_cnt, cycle_limit);
      $display("CHECKS FAILED");
      $finish;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_below(input int n);
      return int'((next_rand() >> 8) % n);
   endfunction

   function automatic noun_pkg::word_t fill_word(input noun_pkg::addr_t a);
      return {2'b01, a, ~a, a ^ 10'h155, a ^ 10'h2aa, {a[4:0], a[9:5]}, a ^ 10'h3c3};
   endfunction

   task automatic check_addr(input noun_pkg::addr_t got, input noun_pkg::addr_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input noun_pkg::word_t got, input noun_pkg::word_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_func(input walk_pkg::mem_func_t got, input walk_pkg::mem_func_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %s expected %s", $time, what,
                  got.name(), exp.name());
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
      end
   endtask

   // Word memory, answers 1 to 4 cycles after each strobe
   always @(negedge clk) begin
      mem_ready = 1'b0;
      if (!rst) begin
         busy = 1'b0;
      end else begin
         if (busy && wait_cnt == 0) begin
            mem_ready = 1'b1;
            if (req_fn == walk_pkg::mem_set) begin
               mem[req_addr] = req_data;
            end else begin
               read_data = mem[req_addr];
            end
            busy = 1'b0;
         end else if (busy) begin
            wait_cnt--;
         end
         if (mem_execute) begin
            busy = 1'b1;
            wait_cnt = rand_below(4);
            req_addr = address;
            req_fn = mem_func;
            req_data = write_data;
            obs_func.push_back(mem_func);
            obs_addr.push_back(address);
            obs_data.push_back(write_data);
         end
      end
   end

   task automatic expect_access(input walk_pkg::mem_func_t f, input noun_pkg::addr_t a,
                                input noun_pkg::word_t d);
      exp_func.push_back(f);
      exp_addr.push_back(a);
      exp_data.push_back(d);
   endtask

   // Depth-first model of the reversal walk; ptr reached this cell, back is its parent
   task automatic predict_walk(input noun_pkg::noun_t ptr, input noun_pkg::noun_t back);
      noun_pkg::addr_t a;
      noun_pkg::word_t w;
      noun_pkg::tag_t  t;
      noun_pkg::noun_t h;
      noun_pkg::noun_t l;
      noun_pkg::tag_t  hs;
      noun_pkg::tag_t  ts;
      a = ptr[noun_pkg::addr_w-1:0];
      w = image[a];
      t = w[noun_pkg::tag_lsb +: noun_pkg::tag_w];
      h = w[noun_pkg::hed_lsb +: noun_pkg::noun_w];
      l = w[noun_pkg::tel_lsb +: noun_pkg::noun_w];
      hs = noun_pkg::tag_t'(1 << noun_pkg::tag_hed_seen_bit);
      ts = noun_pkg::tag_t'(1 << noun_pkg::tag_tel_seen_bit);
      expect_access(walk_pkg::mem_get, a, '0);
      if (t[noun_pkg::tag_hed_cell_bit]) begin
         expect_access(walk_pkg::mem_set, a, {t | hs, back, l});
         predict_walk(h, ptr);
         expect_access(walk_pkg::mem_get, a, '0);
         if (t[noun_pkg::tag_tel_cell_bit]) begin
            // Head restored, tail now holds the back pointer
            expect_access(walk_pkg::mem_set, a, {t | hs | ts, h, back});
            predict_walk(l, ptr);
            expect_access(walk_pkg::mem_get, a, '0);
         end
      end else if (t[noun_pkg::tag_tel_cell_bit]) begin
         expect_access(walk_pkg::mem_set, a, {t | ts, h, back});
         predict_walk(l, ptr);
         expect_access(walk_pkg::mem_get, a, '0);
      end
      // Climbing out rewrites the original cell
      if (t[noun_pkg::tag_hed_cell_bit] || t[noun_pkg::tag_tel_cell_bit]) begin
         expect_access(walk_pkg::mem_set, a, {t & ~(hs | ts), h, l});
      end
   endtask

   task automatic start_walk(input noun_pkg::addr_t root);
      @(negedge clk);
      run = 1'b0;
      start_addr = root;
      for (int a = 0; a < 1024; a++) begin
         mem[a] = image[a];
      end
      exp_func.delete();
      exp_addr.delete();
      exp_data.delete();
      obs_func.delete();
      obs_addr.delete();
      obs_data.delete();
      predict_walk(noun_pkg::noun_t'(root), noun_pkg::noun_t'(noun_pkg::nil_addr));
      cycle_limit += 200 * exp_addr.size() + 50;
      @(negedge clk);
      run = 1'b1;
   endtask

   task automatic finish_walk();
      while (!finished) begin
         @(negedge clk);
      end
      check_flag(obs_addr.size() == exp_addr.size(), 1'b1, "number of memory accesses");
      for (int i = 0; i < exp_addr.size() && i < obs_addr.size(); i++) begin
         check_func(obs_func[i], exp_func[i], $sformatf("function of access %0d", i));
         check_addr(obs_addr[i], exp_addr[i], $sformatf("address of access %0d", i));
         if (exp_func[i] == walk_pkg::mem_set) begin
            check_word(obs_data[i], exp_data[i], $sformatf("data of write %0d", i));
         end
      end
      for (int a = 0; a < 1024; a++) begin
         check_word(mem[a], image[a], $sformatf("word %h after the walk", a));
      end
      @(negedge clk);
      run = 1'b0;
   endtask

   task automatic run_walk(input noun_pkg::addr_t root);
      start_walk(root);
      finish_walk();
   endtask

   `include "tree_walker_tests.svh"

   initial begin
      rst = 1'b0;
      run = 1'b0;
      start_addr = '0;
      mem_ready = 1'b0;
      read_data = '0;
      repeat (4) @(negedge clk);
      rst = 1'b1;
      leaf_root_walk();
      chain_walks();
      random_tree_walks();
      reset_mid_walk();
      assert_fails = dut0.u_control.u_ctrl_assert.fail_count
                   + dut0.u_mem_port.u_port_assert.fail_count;
      $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+verification
verilog/noun_pkg.sv
verilog/walk_pkg.sv
verilog/node_datapath.sv
verilog/mem_port.sv
verilog/walk_control.sv
verilog/tree_walker.sv
verification/tree_walker_assert.sv
verification/tree_walker_tb.sv
